// ==== k005293_top.sv ====
// Priority handler top level that ties the shifter, sprite latch and mixer to the chip pinout
`timescale 1ns/100ps
`default_nettype none

module k005293_top (
    input  logic                        i_EMU_MCLK,
    input  logic                        i_arst_n,
    input  logic                        i_EMU_CLK6MPCEN_n,
    input  logic                        i_HFLIP,
    input  logic                        i_SHIFTA1,
    input  logic                        i_SHIFTA2,
    input  logic                        i_SHIFTB,
    input  logic                        i_ABS_n1H,
    input  logic                        i_ABS_n6n7H,
    input  logic                        i_ABS_n2n3H,
    input  prihandler_pkg::pixel_t      i_A_PIXEL,
    input  prihandler_pkg::pixel_t      i_B_PIXEL,
    input  logic [15:0]                 i_OBJBUF_DATA,   // Two sprite pixels
    input  logic                        i_A_TRN_n,
    input  logic                        i_B_TRN_n,
    input  logic                        i_VHFF,
    input  prihandler_pkg::palette_t    i_VC,
    input  prihandler_pkg::pr_a_t       i_PR,
    output logic                        o_A_FLIP,
    output logic                        o_B_FLIP,
    output prihandler_pkg::color_code_t o_CD
);

    prihandler_pkg::obj_pixel_t obj_pixel;

    tile_prop_if u_prop ();

    tile_prop_shifter u_shifter (
        .i_EMU_MCLK        (i_EMU_MCLK),
        .i_arst_n          (i_arst_n),
        .i_EMU_CLK6MPCEN_n (i_EMU_CLK6MPCEN_n),
        .i_ABS_n1H         (i_ABS_n1H),
        .i_ABS_n2n3H       (i_ABS_n2n3H),
        .i_ABS_n6n7H       (i_ABS_n6n7H),
        .i_SHIFTA1         (i_SHIFTA1),
        .i_SHIFTA2         (i_SHIFTA2),
        .i_SHIFTB          (i_SHIFTB),
        .i_PR              (i_PR),
        .i_VHFF            (i_VHFF),
        .i_VC              (i_VC),
        .o_A_FLIP          (o_A_FLIP),
        .o_B_FLIP          (o_B_FLIP),
        .prop              (u_prop.shifter)
    );

    obj_pixel_latch u_obj_latch (
        .i_EMU_MCLK        (i_EMU_MCLK),
        .i_arst_n          (i_arst_n),
        .i_EMU_CLK6MPCEN_n (i_EMU_CLK6MPCEN_n),
        .i_ABS_n1H         (i_ABS_n1H),
        .i_HFLIP           (i_HFLIP),
        .i_OBJBUF_DATA     (i_OBJBUF_DATA),
        .o_obj_pixel       (obj_pixel)
    );

    layer_priority_mixer u_mixer (
        .i_EMU_MCLK        (i_EMU_MCLK),
        .i_arst_n          (i_arst_n),
        .i_EMU_CLK6MPCEN_n (i_EMU_CLK6MPCEN_n),
        .prop              (u_prop.mixer),
        .i_obj_pixel       (obj_pixel),
        .i_A_PIXEL         (i_A_PIXEL),
        .i_B_PIXEL         (i_B_PIXEL),
        .i_A_TRN_n         (i_A_TRN_n),
        .i_B_TRN_n         (i_B_TRN_n),
        .o_CD              (o_CD)
    );

endmodule

`default_nettype wire

// ==== layer_priority_mixer.sv ====
// Priority decode of the tile and sprite layers and the registered palette code output
`timescale 1ns/100ps
`default_nettype none

module layer_priority_mixer (
    input  logic                        i_EMU_MCLK,
    input  logic                        i_arst_n,
    input  logic                        i_EMU_CLK6MPCEN_n,
    tile_prop_if.mixer                  prop,
    input  prihandler_pkg::obj_pixel_t  i_obj_pixel,
    input  prihandler_pkg::pixel_t      i_A_PIXEL,
    input  prihandler_pkg::pixel_t      i_B_PIXEL,
    input  logic                        i_A_TRN_n,
    input  logic                        i_B_TRN_n,
    output prihandler_pkg::color_code_t o_CD
);

    prihandler_pkg::prmode_e mode;
    prihandler_pkg::layer_e  layer;
    logic                    obj_trn;
    logic [2:0]              trn;   // {A, B, OBJ} set when transparent
    logic [15:0]             row;   // Layer codes for trn 7 down to 0

    assign obj_trn = (i_obj_pixel[3:0] == 4'h0);
    assign trn     = {~i_A_TRN_n, ~i_B_TRN_n, obj_trn};

    ////////////////////
    // Mode decode
    // First match wins since several codes share a mode
    always_comb begin
        casez ({prop.b_pr, prop.a_pr})
            6'b??_0101: mode = prihandler_pkg::PR_A;
            6'b?1_1101: mode = prihandler_pkg::PR_A_B;
            6'b?1_1111: mode = prihandler_pkg::PR_A_B_O;
            6'b00_1101: mode = prihandler_pkg::PR_A_BMO;
            6'b??_0111: mode = prihandler_pkg::PR_A_O1;
            6'b00_1111: mode = prihandler_pkg::PR_A_O2;
            6'b10_1111: mode = prihandler_pkg::PR_A_O_B;
            6'b01_00??: mode = prihandler_pkg::PR_B;
            6'b01_10?1: mode = prihandler_pkg::PR_B_A;
            6'b11_10?1: mode = prihandler_pkg::PR_B_A_O;
            6'b11_00??: mode = prihandler_pkg::PR_B_O;
            6'b11_1000: mode = prihandler_pkg::PR_B_O;
            6'b11_1010: mode = prihandler_pkg::PR_B_O_A;
            6'b00_00??: mode = prihandler_pkg::PR_O;
            6'b00_1?00: mode = prihandler_pkg::PR_O;
            6'b??_0100: mode = prihandler_pkg::PR_O;
            6'b??_0110: mode = prihandler_pkg::PR_O_A;
            6'b00_1110: mode = prihandler_pkg::PR_O_A;
            6'b10_1110: mode = prihandler_pkg::PR_O_A_B;
            6'b10_00??: mode = prihandler_pkg::PR_O_B;
            6'b10_1000: mode = prihandler_pkg::PR_O_B;
            6'b10_1010: mode = prihandler_pkg::PR_O_B_A;
            6'b10_1101: mode = prihandler_pkg::PR_A_BMO_B;
            6'b?1_1100: mode = prihandler_pkg::PR_APB_O;
            6'b?1_1110: mode = prihandler_pkg::PR_APB_O_A;
            6'b01_1000: mode = prihandler_pkg::PR_B_AMO;
            6'b01_1010: mode = prihandler_pkg::PR_B_AMO_A;
            6'b00_10?1: mode = prihandler_pkg::PR_BPA_O;
            6'b10_10?1: mode = prihandler_pkg::PR_BPA_O_B;
            6'b10_1100: mode = prihandler_pkg::PR_O_APB;
            6'b00_1010: mode = prihandler_pkg::PR_O_BPA;
            default:    mode = prihandler_pkg::PR_A;   // Undecoded codes show A
        endcase
    end

    ////////////////////
    // Layer table
    // Codes are 00 for A, 01 for B and 10 for the sprite with trn 7 as the leftmost pair
    always_comb begin
        case (mode)
            prihandler_pkg::PR_A:       row = 16'b00_00_00_00_00_00_00_00;
            prihandler_pkg::PR_A_B:     row = 16'b00_00_01_01_00_00_00_00;
            prihandler_pkg::PR_A_B_O:   row = 16'b00_10_01_01_00_00_00_00;
            prihandler_pkg::PR_A_BMO:   row = 16'b00_00_10_10_00_00_00_00;
            prihandler_pkg::PR_A_O1:    row = 16'b00_10_00_10_00_00_00_00;
            prihandler_pkg::PR_A_O2:    row = 16'b00_10_10_10_00_00_00_00;
            prihandler_pkg::PR_A_O_B:   row = 16'b00_10_01_10_00_00_00_00;
            prihandler_pkg::PR_B:       row = 16'b01_01_01_01_01_01_01_01;
            prihandler_pkg::PR_B_A:     row = 16'b01_01_01_01_00_00_01_01;
            prihandler_pkg::PR_B_A_O:   row = 16'b10_10_01_01_00_00_01_01;
            prihandler_pkg::PR_B_O:     row = 16'b10_10_01_01_10_10_01_01;
            prihandler_pkg::PR_B_O_A:   row = 16'b10_10_01_01_00_10_01_01;
            prihandler_pkg::PR_O:       row = 16'b10_10_10_10_10_10_10_10;
            prihandler_pkg::PR_O_A:     row = 16'b10_10_10_10_00_10_00_10;
            prihandler_pkg::PR_O_A_B:   row = 16'b10_10_01_10_00_10_00_10;
            prihandler_pkg::PR_O_B:     row = 16'b10_10_01_10_10_10_01_10;
            prihandler_pkg::PR_O_B_A:   row = 16'b10_10_01_10_00_10_01_10;
            prihandler_pkg::PR_A_BMO_B: row = 16'b00_00_01_10_00_00_00_00;
            prihandler_pkg::PR_APB_O:   row = 16'b10_10_01_01_10_10_10_10;
            prihandler_pkg::PR_APB_O_A: row = 16'b10_10_01_01_00_10_00_10;
            prihandler_pkg::PR_B_AMO:   row = 16'b01_01_01_01_10_10_01_01;
            prihandler_pkg::PR_B_AMO_A: row = 16'b01_01_01_01_00_10_01_01;
            prihandler_pkg::PR_BPA_O:   row = 16'b10_10_10_10_00_00_10_10;
            prihandler_pkg::PR_BPA_O_B: row = 16'b10_10_01_10_00_00_01_10;
            prihandler_pkg::PR_O_APB:   row = 16'b10_10_01_10_10_10_10_10;
            prihandler_pkg::PR_O_BPA:   row = 16'b10_10_10_10_00_10_10_10;
            default:                    row = 16'b00_00_00_00_00_00_00_00;
        endcase
    end

    assign layer = prihandler_pkg::layer_e'(row[2*trn +: 2]);

    ////////////////////
    // Output register
    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_CD <= '0;
        end else if (!i_EMU_CLK6MPCEN_n) begin
            case (layer)
                prihandler_pkg::TMA: o_CD <= {prop.a_palette, i_A_PIXEL};
                prihandler_pkg::TMB: o_CD <= {prop.b_palette, i_B_PIXEL};
                default:             o_CD <= {3'b000, i_obj_pixel};   // Sprite palette
            endcase
        end
    end

    a_layer_legal: assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
        !i_EMU_CLK6MPCEN_n |-> layer inside {prihandler_pkg::TMA,
                                             prihandler_pkg::TMB,
                                             prihandler_pkg::OBJ})
        else $error("Layer table produced an illegal layer code");

endmodule

`default_nettype wire

// ==== obj_pixel_latch.sv ====
// Sprite pixel pair latch that presents one pixel per half period according to flip
`timescale 1ns/100ps
`default_nettype none

module obj_pixel_latch (
    input  logic                       i_EMU_MCLK,
    input  logic                       i_arst_n,
    input  logic                       i_EMU_CLK6MPCEN_n,
    input  logic                       i_ABS_n1H,
    input  logic                       i_HFLIP,
    input  logic [15:0]                i_OBJBUF_DATA,
    output prihandler_pkg::obj_pixel_t o_obj_pixel
);

    prihandler_pkg::obj_pixel_t pixel0_q;   // Even pixel from the low byte
    prihandler_pkg::obj_pixel_t pixel1_q;   // Odd pixel from the high byte

    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pixel0_q <= '0;
            pixel1_q <= '0;
        end else if (!i_EMU_CLK6MPCEN_n && !i_ABS_n1H) begin
            pixel1_q <= i_OBJBUF_DATA[15:8];
            pixel0_q <= i_OBJBUF_DATA[7:0];
        end
    end

    // The even pixel shows while 1H is low unless flipped
    assign o_obj_pixel = (i_ABS_n1H != i_HFLIP) ? pixel0_q : pixel1_q;

    a_objbuf_known: assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
        (!i_EMU_CLK6MPCEN_n && !i_ABS_n1H) |-> !$isunknown(i_OBJBUF_DATA))
        else $error("Sprite buffer data unknown while latching");

endmodule

`default_nettype wire

// ==== prihandler_pkg.sv ====
// Shared types of the priority handler that the RTL files reference by scoped name
`default_nettype none

`include "prihandler_settings.svh"

package prihandler_pkg;

    typedef logic [`PIXEL_W-1:0]     pixel_t;
    typedef logic [`PALETTE_W-1:0]   palette_t;
    typedef logic [`PR_A_W-1:0]      pr_a_t;
    typedef logic [`PR_B_W-1:0]      pr_b_t;
    typedef logic [`OBJ_PIXEL_W-1:0] obj_pixel_t;
    typedef logic [`CD_W-1:0]        color_code_t;

    // Layer that reaches the output
    typedef enum logic [1:0] {
        TMA = 2'b00,
        TMB = 2'b01,
        OBJ = 2'b10
    } layer_e;

    // Priority modes named by display order from front to back
    typedef enum logic [4:0] {
        PR_A,
        PR_A_B,
        PR_A_B_O,
        PR_A_BMO,       // A on top and B cutting a window out of the sprite
        PR_A_O1,
        PR_A_O2,
        PR_A_O_B,
        PR_B,
        PR_B_A,
        PR_B_A_O,
        PR_B_O,
        PR_B_O_A,
        PR_O,
        PR_O_A,
        PR_O_A_B,
        PR_O_B,
        PR_O_B_A,
        PR_A_BMO_B,
        PR_APB_O,       // A punches holes in B
        PR_APB_O_A,
        PR_B_AMO,
        PR_B_AMO_A,
        PR_BPA_O,       // B punches holes in A
        PR_BPA_O_B,
        PR_O_APB,
        PR_O_BPA
    } prmode_e;

endpackage

`default_nettype wire

// ==== prihandler_settings.svh ====
// Field widths of the priority handler; include wherever the widths are needed
`ifndef PRIHANDLER_SETTINGS_SVH
`define PRIHANDLER_SETTINGS_SVH

`define PIXEL_W      4   // Tile pixel index
`define PALETTE_W    7   // Tile palette code
`define PR_A_W       4   // Layer A priority bits
`define PR_B_W       2   // Layer B priority bits
`define OBJ_PIXEL_W  8   // Sprite pixel with a zero low nibble as transparent
`define CD_W         11  // Palette code to the color RAM

`endif

// ==== sim.f ====
+incdir+.
prihandler_pkg.sv
tile_prop_if.sv
tile_prop_shifter.sv
obj_pixel_latch.sv
layer_priority_mixer.sv
k005293_top.sv
tb_k005293.sv

// ==== tb_k005293.sv ====
// Directed testbench that runs as the simulation top and checks the priority handler
`timescale 1ns/100ps
`default_nettype none

`include "prihandler_settings.svh"

module tb_k005293;

    localparam int CLK_HALF  = 20;
    localparam int DRIVE_DLY = 2;
    localparam int RST_CYC   = 8;
    localparam int MAX_CYC   = 3000;

    logic                        i_EMU_MCLK;
    logic                        i_arst_n;
    logic                        i_EMU_CLK6MPCEN_n;
    logic                        i_HFLIP;
    logic                        i_SHIFTA1;
    logic                        i_SHIFTA2;
    logic                        i_SHIFTB;
    logic                        i_ABS_n1H;
    logic                        i_ABS_n6n7H;
    logic                        i_ABS_n2n3H;
    prihandler_pkg::pixel_t      i_A_PIXEL;
    prihandler_pkg::pixel_t      i_B_PIXEL;
    logic [15:0]                 i_OBJBUF_DATA;
    logic                        i_A_TRN_n;
    logic                        i_B_TRN_n;
    logic                        i_VHFF;
    prihandler_pkg::palette_t    i_VC;
    prihandler_pkg::pr_a_t       i_PR;
    logic                        o_A_FLIP;
    logic                        o_B_FLIP;
    prihandler_pkg::color_code_t o_CD;

    integer                   seed;
    int                       checks;
    int                       errors;
    prihandler_pkg::palette_t a_pal;   // Palette now in A stage 4
    prihandler_pkg::palette_t b_pal;   // Palette now in B stage 3

    k005293_top DUT (.*);

    initial begin
        i_EMU_MCLK = 1'b0;
        forever #CLK_HALF i_EMU_MCLK = ~i_EMU_MCLK;
    end

    ////////////////////
    // Helpers
    task automatic next_cycle();
        @(posedge i_EMU_MCLK);
        #DRIVE_DLY;
    endtask

    task automatic wait_cycles(input int n);
        for (int c = 0; c < n; c++)
            next_cycle();
    endtask

    task automatic check_cd(input prihandler_pkg::color_code_t got,
                            input prihandler_pkg::color_code_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED o_CD got %h expected %h (%s)", got, exp, what);
        end
    endtask

    task automatic check_flip(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // First opaque layer in display order or the front layer if none is opaque
    function automatic prihandler_pkg::layer_e pick_layer(
        input prihandler_pkg::layer_e l0, l1, l2,
        input int count,
        input logic a_op, b_op, o_op);
        prihandler_pkg::layer_e order [0:2];
        prihandler_pkg::layer_e result;
        logic                   op;
        order[0] = l0;
        order[1] = l1;
        order[2] = l2;
        result   = l0;
        for (int k = count - 1; k >= 0; k--) begin
            case (order[k])
                prihandler_pkg::TMA: op = a_op;
                prihandler_pkg::TMB: op = b_op;
                default:             op = o_op;
            endcase
            if (op)
                result = order[k];
        end
        return result;
    endfunction

    function automatic prihandler_pkg::color_code_t expect_cd(
        input prihandler_pkg::layer_e layer, input prihandler_pkg::obj_pixel_t obj);
        prihandler_pkg::color_code_t cd;
        case (layer)
            prihandler_pkg::TMA: cd = {a_pal, i_A_PIXEL};
            prihandler_pkg::TMB: cd = {b_pal, i_B_PIXEL};
            default:             cd = {3'b000, obj};
        endcase
        return cd;
    endfunction

    ////////////////////
    // Stimulus
    task automatic load_props(input prihandler_pkg::pr_a_t pr_a, input logic flip_a,
                              input prihandler_pkg::palette_t pal_a,
                              input prihandler_pkg::pr_b_t pr_b, input logic flip_b,
                              input prihandler_pkg::palette_t pal_b);
        i_ABS_n1H   = 1'b0;
        i_PR        = pr_a;
        i_VHFF      = flip_a;
        i_VC        = pal_a;
        i_ABS_n2n3H = 1'b0;          // A stage 1
        next_cycle();
        i_ABS_n2n3H = 1'b1;
        i_PR        = {~pr_b, pr_b}; // B keeps the low bits only
        i_VHFF      = flip_b;
        i_VC        = pal_b;
        i_ABS_n6n7H = 1'b0;          // A stage 2 and B stage 1
        next_cycle();
        i_ABS_n6n7H = 1'b1;
        i_SHIFTA1   = 1'b0;
        next_cycle();
        i_SHIFTA1   = 1'b1;
        i_SHIFTA2   = 1'b0;
        next_cycle();
        i_SHIFTA2   = 1'b1;
        i_ABS_n2n3H = 1'b0;          // B stage 2
        next_cycle();
        i_ABS_n2n3H = 1'b1;
        i_SHIFTB    = 1'b0;
        next_cycle();
        i_SHIFTB    = 1'b1;
        i_ABS_n1H   = 1'b1;
        a_pal       = pal_a;
        b_pal       = pal_b;
    endtask

    task automatic load_obj(input logic [15:0] word);
        i_OBJBUF_DATA = word;
        i_ABS_n1H     = 1'b0;
        next_cycle();
        i_ABS_n1H     = 1'b1;
    endtask

    ////////////////////
    // Tests
    task automatic reset_state();
        check_cd(o_CD, '0, "after reset");
        check_flip(o_A_FLIP, 1'b0, "o_A_FLIP");
        check_flip(o_B_FLIP, 1'b0, "o_B_FLIP");
    endtask

    task automatic run_mode(input logic [1:0] b_code, input logic [3:0] a_code,
                            input prihandler_pkg::layer_e l0, l1, l2, input int count);
        logic [31:0]            rnd;
        logic [15:0]            word;
        logic [2:0]             trn;     // {A, B, sprite} transparent
        prihandler_pkg::layer_e exp_layer;
        rnd = $random(seed);
        load_props(a_code, rnd[16], rnd[6:0], b_code, rnd[17], rnd[14:8]);
        i_HFLIP = 1'b0;
        for (int combo = 0; combo < 8; combo++) begin
            trn  = combo[2:0];
            rnd  = $random(seed);
            word = rnd[15:0];
            if (trn[0])
                word[3:0] = 4'h0;
            else if (word[3:0] == 4'h0)
                word[3:0] = 4'h9;
            load_obj(word);
            i_A_TRN_n = ~trn[2];
            i_B_TRN_n = ~trn[1];
            rnd       = $random(seed);
            i_A_PIXEL = rnd[3:0];
            i_B_PIXEL = rnd[7:4];
            exp_layer = pick_layer(l0, l1, l2, count, ~trn[2], ~trn[1],
                                   word[3:0] != 4'h0);
            next_cycle();
            check_cd(o_CD, expect_cd(exp_layer, word[`OBJ_PIXEL_W-1:0]),
                     $sformatf("mode %b/%b trn %b", b_code, a_code, trn));
        end
    endtask

    task automatic flip_select();
        logic [31:0] rnd;
        logic [15:0] word;
        rnd  = $random(seed);
        word = rnd[15:0];
        load_props(4'b0000, 1'b0, 7'h11, 2'b00, 1'b0, 7'h22);   // Sprite only
        load_obj(word);
        i_HFLIP = 1'b0;
        next_cycle();
        check_cd(o_CD, {3'b000, word[7:0]}, "sprite no flip");
        i_HFLIP = 1'b1;
        next_cycle();
        check_cd(o_CD, {3'b000, word[15:8]}, "sprite flipped");
        i_HFLIP = 1'b0;
    endtask

    task automatic props_hold();
        load_props(4'b0101, 1'b1, 7'h35, 2'b10, 1'b0, 7'h4A);
        check_flip(o_A_FLIP, 1'b1, "o_A_FLIP");
        check_flip(o_B_FLIP, 1'b0, "o_B_FLIP");
        load_props(4'b0101, 1'b0, 7'h5C, 2'b01, 1'b1, 7'h23);
        check_flip(o_A_FLIP, 1'b0, "o_A_FLIP");
        check_flip(o_B_FLIP, 1'b1, "o_B_FLIP");
        i_A_PIXEL = 4'hB;
        i_A_TRN_n = 1'b1;
        next_cycle();
        check_cd(o_CD, {7'h5C, 4'hB}, "A only");
        i_PR   = 4'b0000;   // Sprite only if it were loaded
        i_VC   = 7'h7F;
        i_VHFF = 1'b1;
        wait_cycles(6);     // Long enough to pass all four A stages
        check_cd(o_CD, {7'h5C, 4'hB}, "PR changed without strobes");
        check_flip(o_A_FLIP, 1'b0, "o_A_FLIP");
    endtask

    task automatic enable_hold();
        i_A_PIXEL = 4'h6;
        next_cycle();
        check_cd(o_CD, {a_pal, 4'h6}, "before hold");
        i_EMU_CLK6MPCEN_n = 1'b1;
        i_A_PIXEL         = 4'hE;
        i_B_PIXEL         = 4'h3;
        i_A_TRN_n         = 1'b0;
        wait_cycles(4);
        check_cd(o_CD, {a_pal, 4'h6}, "enable high");
        i_EMU_CLK6MPCEN_n = 1'b0;
        i_A_TRN_n         = 1'b1;
        next_cycle();
        check_cd(o_CD, {a_pal, 4'hE}, "enable restored");
    endtask

    ////////////////////
    // Main sequence
    initial begin
        seed              = 3837;
        checks            = 0;
        errors            = 0;
        a_pal             = '0;
        b_pal             = '0;
        i_arst_n          = 1'b0;
        i_EMU_CLK6MPCEN_n = 1'b0;
        i_HFLIP           = 1'b0;
        i_SHIFTA1         = 1'b1;
        i_SHIFTA2         = 1'b1;
        i_SHIFTB          = 1'b1;
        i_ABS_n1H         = 1'b1;
        i_ABS_n6n7H       = 1'b1;
        i_ABS_n2n3H       = 1'b1;
        i_A_PIXEL         = '0;
        i_B_PIXEL         = '0;
        i_OBJBUF_DATA     = '0;
        i_A_TRN_n         = 1'b1;
        i_B_TRN_n         = 1'b1;
        i_VHFF            = 1'b0;
        i_VC              = '0;
        i_PR              = '0;
        wait_cycles(RST_CYC);
        i_arst_n = 1'b1;

        reset_state();
        run_mode(2'b01, 4'b0000, prihandler_pkg::TMB, prihandler_pkg::TMB,
                 prihandler_pkg::TMB, 1);
        run_mode(2'b00, 4'b0000, prihandler_pkg::OBJ, prihandler_pkg::OBJ,
                 prihandler_pkg::OBJ, 1);
        run_mode(2'b00, 4'b0101, prihandler_pkg::TMA, prihandler_pkg::TMA,
                 prihandler_pkg::TMA, 1);
        run_mode(2'b01, 4'b1101, prihandler_pkg::TMA, prihandler_pkg::TMB,
                 prihandler_pkg::TMA, 2);
        run_mode(2'b01, 4'b1111, prihandler_pkg::TMA, prihandler_pkg::TMB,
                 prihandler_pkg::OBJ, 3);
        run_mode(2'b01, 4'b1001, prihandler_pkg::TMB, prihandler_pkg::TMA,
                 prihandler_pkg::TMA, 2);
        run_mode(2'b10, 4'b1110, prihandler_pkg::OBJ, prihandler_pkg::TMA,
                 prihandler_pkg::TMB, 3);
        run_mode(2'b10, 4'b1010, prihandler_pkg::OBJ, prihandler_pkg::TMB,
                 prihandler_pkg::TMA, 3);
        flip_select();
        props_hold();
        enable_hold();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Watchdog against a stalled run
    initial begin
        for (int c = 0; c < MAX_CYC; c++)
            @(posedge i_EMU_MCLK);
        $display("Timeout after %0d clock cycles, test sequence did not finish", MAX_CYC);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tile_prop_if.sv ====
// Delayed tile properties handed from the property shifter to the layer mixer
`timescale 1ns/100ps
`default_nettype none

interface tile_prop_if;

    prihandler_pkg::pr_a_t    a_pr;       // From A stage 4
    prihandler_pkg::palette_t a_palette;
    prihandler_pkg::pr_b_t    b_pr;       // From B stage 3
    prihandler_pkg::palette_t b_palette;

    modport shifter (
        output a_pr,
        output a_palette,
        output b_pr,
        output b_palette
    );

    modport mixer (
        input  a_pr,
        input  a_palette,
        input  b_pr,
        input  b_palette
    );

endinterface

`default_nettype wire

// ==== tile_prop_shifter.sv ====
// Strobed delay chains that carry tile priority, flip and palette for layers A and B
`timescale 1ns/100ps
`default_nettype none

module tile_prop_shifter (
    input  logic                     i_EMU_MCLK,
    input  logic                     i_arst_n,
    input  logic                     i_EMU_CLK6MPCEN_n,
    input  logic                     i_ABS_n1H,
    input  logic                     i_ABS_n2n3H,
    input  logic                     i_ABS_n6n7H,
    input  logic                     i_SHIFTA1,
    input  logic                     i_SHIFTA2,
    input  logic                     i_SHIFTB,
    input  prihandler_pkg::pr_a_t    i_PR,
    input  logic                     i_VHFF,
    input  prihandler_pkg::palette_t i_VC,
    output logic                     o_A_FLIP,
    output logic                     o_B_FLIP,
    tile_prop_if.shifter             prop
);

    prihandler_pkg::pr_a_t    a_pr_q   [1:4];
    logic                     a_flip_q [1:4];
    prihandler_pkg::palette_t a_pal_q  [1:4];
    prihandler_pkg::pr_b_t    b_pr_q   [1:3];
    logic                     b_flip_q [1:3];
    prihandler_pkg::palette_t b_pal_q  [1:3];

    logic [4:1] a_shift;    // Active-high load per stage
    logic [3:1] b_shift;

    ////////////////////
    // Strobe decode
    assign a_shift = {~i_SHIFTA2, ~i_SHIFTA1,
                      ~(i_ABS_n1H | i_ABS_n6n7H), ~(i_ABS_n1H | i_ABS_n2n3H)};
    assign b_shift = {~i_SHIFTB, ~(i_ABS_n1H | i_ABS_n2n3H), ~(i_ABS_n1H | i_ABS_n6n7H)};

    ////////////////////
    // Delay chains
    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i <= 4; i++) begin
                a_pr_q[i]   <= '0;
                a_flip_q[i] <= 1'b0;
                a_pal_q[i]  <= '0;
            end
            for (int j = 1; j <= 3; j++) begin
                b_pr_q[j]   <= '0;
                b_flip_q[j] <= 1'b0;
                b_pal_q[j]  <= '0;
            end
        end else if (!i_EMU_CLK6MPCEN_n) begin
            if (a_shift[1]) begin   // Pixel 3 of the character
                a_pr_q[1]   <= i_PR;
                a_flip_q[1] <= i_VHFF;
                a_pal_q[1]  <= i_VC;
            end
            for (int i = 2; i <= 4; i++) begin
                if (a_shift[i]) begin
                    a_pr_q[i]   <= a_pr_q[i-1];
                    a_flip_q[i] <= a_flip_q[i-1];
                    a_pal_q[i]  <= a_pal_q[i-1];
                end
            end
            if (b_shift[1]) begin   // Pixel 7 with only two B priority bits
                b_pr_q[1]   <= i_PR[1:0];
                b_flip_q[1] <= i_VHFF;
                b_pal_q[1]  <= i_VC;
            end
            for (int j = 2; j <= 3; j++) begin
                if (b_shift[j]) begin
                    b_pr_q[j]   <= b_pr_q[j-1];
                    b_flip_q[j] <= b_flip_q[j-1];
                    b_pal_q[j]  <= b_pal_q[j-1];
                end
            end
        end
    end

    assign o_A_FLIP       = a_flip_q[3];   // One stage ahead of the A palette
    assign o_B_FLIP       = b_flip_q[3];
    assign prop.a_pr      = a_pr_q[4];
    assign prop.a_palette = a_pal_q[4];
    assign prop.b_pr      = b_pr_q[3];
    assign prop.b_palette = b_pal_q[3];

    a_strobe_known: assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
        !i_EMU_CLK6MPCEN_n |-> !$isunknown({i_ABS_n1H, i_ABS_n2n3H, i_ABS_n6n7H,
                                            i_SHIFTA1, i_SHIFTA2, i_SHIFTB}))
        else $error("Timing strobe unknown on an enabled edge");

endmodule

`default_nettype wire
